/* source/ifu_macros.svh */
//----------------------------
// Fetch unit widths and sizes
// Queue capacity and counter widths
//----------------------------

`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

`define IFU_XLEN          32                              // Address and data width
`define IFU_Q_SIZE_WORD   2                               // Queue capacity in words
`define IFU_Q_SIZE_HALF   (`IFU_Q_SIZE_WORD * 2)          // Queue capacity in halfwords
`define IFU_Q_ADR_W       $clog2(`IFU_Q_SIZE_HALF)        // Queue index without wrap bit
`define IFU_Q_FREE_W_W    $clog2(`IFU_Q_SIZE_WORD + 1)    // Free word count width

// All ones in the outstanding counter means full
`define IFU_TXN_CNT_W     3

`endif

/* source/ifu_pkg.sv */
//----------------------------
// Fetch unit shared types
// Vector typedefs and enums
//----------------------------

`default_nettype none

`include "ifu_macros.svh"

package ifu_pkg;

    //----------------------------
    // Vectors
    //----------------------------
    typedef logic [`IFU_XLEN-1:0]      xlen_t;        // Full address or data word
    typedef logic [`IFU_XLEN-3:0]      word_addr_t;   // Word address, low two bits dropped
    typedef logic [`IFU_XLEN/2-1:0]    half_t;        // One instruction halfword
    typedef logic [`IFU_XLEN-1:0]      instr_t;       // Instruction to the decoder
    typedef logic [`IFU_TXN_CNT_W-1:0] txn_cnt_t;     // Outstanding or discard count
    typedef logic [`IFU_Q_ADR_W:0]     q_ptr_t;       // Queue pointer with wrap bit

    //----------------------------
    // Enums
    //----------------------------
    typedef enum logic [1:0] {
        resp_notrdy = 2'd0,    // No response this cycle
        resp_rdy_ok = 2'd1,    // Data valid
        resp_rdy_er = 2'd2     // Access fault
    } mem_resp_e;

    typedef enum logic {
        fsm_idle,
        fsm_fetch
    } fetch_state_e;

    typedef enum logic [1:0] {
        we_none,               // Nothing written
        we_full,               // Both halves of rdata
        we_hi                  // Upper half of rdata only
    } q_we_e;

    // Named as upper half then lower half of the word
    typedef enum logic [2:0] {
        rdata_none,            // No kept data
        rdata_rvi_hi_rvi_lo,   // Whole aligned RVI
        rdata_rvc_rvc,
        rdata_rvi_lo_rvc,
        rdata_rvc_rvi_hi,
        rdata_rvi_lo_rvi_hi,
        rdata_rvc_nv,          // First word after unaligned PC
        rdata_rvi_lo_nv        // First word after unaligned PC
    } rdata_ident_e;

    typedef enum logic {
        rvi_part2,             // Next word starts with an RVI upper half
        rdata_other
    } rdata_type_e;

endpackage

`default_nettype wire

/* source/fetch_ctrl.sv */
//----------------------------
// Instruction fetch controller
// Idle and fetch FSM, request address
// Outstanding and discard counters
//----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        new_pc_req,     // Redirect request
    input  ifu_pkg::xlen_t              new_pc,
    input  logic                        stop_fetch,
    output logic                        imem_req,
    input  logic                        imem_req_ack,
    output ifu_pkg::xlen_t              imem_addr,      // Always word aligned
    input  ifu_pkg::mem_resp_e          imem_resp,
    input  logic [`IFU_Q_FREE_W_W-1:0]  q_free_words,   // Free words after this cycle's read
    output logic                        resp_keep,      // Current response goes to the queue
    output logic                        fetch_active,
    output logic                        ifu_busy
);

    import ifu_pkg::*;

    fetch_state_e fsm;
    word_addr_t   addr_r;
    word_addr_t   addr_base;
    txn_cnt_t     txns_pending;       // Sent but not yet answered
    txn_cnt_t     txns_pending_new;
    txn_cnt_t     discard_cnt;        // Responses still to drop
    txn_cnt_t     discard_cnt_new;
    txn_cnt_t     vd_txns_pending;    // Pending ones that will be kept
    logic         txns_full;
    logic         txn_accept;
    logic         resp_vld;
    logic         resp_er;
    logic         discard;

    //----------------------------
    // Response decode
    //----------------------------
    assign resp_er   = (imem_resp == resp_rdy_er);
    assign resp_vld  = (imem_resp == resp_rdy_ok) || resp_er;
    assign discard   = |discard_cnt;
    assign resp_keep = resp_vld && !discard;

    //----------------------------
    // Memory request
    //----------------------------
    assign txns_full       = &txns_pending;
    assign vd_txns_pending = txns_pending - discard_cnt;
    assign txn_accept      = imem_req && imem_req_ack;

    // Queue is flushed on redirect so the free space check only applies while fetching
    assign imem_req = !txns_full && !stop_fetch &&
                      (new_pc_req ||
                       ((fsm == fsm_fetch) && (txn_cnt_t'(q_free_words) > vd_txns_pending)));

    assign addr_base = new_pc_req ? new_pc[`IFU_XLEN-1:2] : addr_r;
    assign imem_addr = {addr_base, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_r <= '0;
        end else if (txn_accept) begin
            addr_r <= addr_base + 1'b1;            // Next sequential word
        end else if (new_pc_req) begin
            addr_r <= new_pc[`IFU_XLEN-1:2];
        end
    end

    //----------------------------
    // Transaction counters
    //----------------------------
    assign txns_pending_new = txns_pending + txn_cnt_t'(txn_accept) - txn_cnt_t'(resp_vld);

    always_comb begin
        if (new_pc_req || stop_fetch) begin
            discard_cnt_new = txns_pending_new - txn_cnt_t'(txn_accept);  // Older ones only
        end else if (resp_er && !discard) begin
            discard_cnt_new = txns_pending_new;    // Drop everything after a fault
        end else if (resp_vld && discard) begin
            discard_cnt_new = discard_cnt - 1'b1;
        end else begin
            discard_cnt_new = discard_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txns_pending <= '0;
            discard_cnt  <= '0;
        end else begin
            txns_pending <= txns_pending_new;
            discard_cnt  <= discard_cnt_new;
        end
    end

    //----------------------------
    // Fetch FSM
    //----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm <= fsm_idle;
        end else begin
            case (fsm)
                fsm_idle: begin
                    if (new_pc_req && !stop_fetch) begin
                        fsm <= fsm_fetch;
                    end
                end
                default: begin
                    if (stop_fetch || (resp_er && !discard && !new_pc_req)) begin
                        fsm <= fsm_idle;
                    end
                end
            endcase
        end
    end

    assign fetch_active = (fsm == fsm_fetch);
    assign ifu_busy     = fetch_active;

endmodule

`default_nettype wire

/* source/rdata_classify.sv */
//----------------------------
// Response content classifier
// Halfword identification and queue write kind
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module rdata_classify (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                new_pc_req,
    input  logic                new_pc_half,    // Bit 1 of the new PC
    input  ifu_pkg::mem_resp_e  imem_resp,
    input  ifu_pkg::xlen_t      imem_rdata,
    input  logic                resp_keep,
    output ifu_pkg::q_we_e      q_we
);

    import ifu_pkg::*;

    rdata_ident_e rdata_ident;
    rdata_type_e  rdata_curr;
    rdata_type_e  rdata_next;
    logic         new_pc_unaligned;   // First word after redirect starts mid word
    logic         resp_ok;
    logic         resp_er;
    logic         lo_rvi;
    logic         hi_rvi;

    assign resp_ok = (imem_resp == resp_rdy_ok);
    assign resp_er = (imem_resp == resp_rdy_er);
    assign lo_rvi  = &imem_rdata[1:0];
    assign hi_rvi  = &imem_rdata[17:16];

    //----------------------------
    // Content class
    //----------------------------
    always_comb begin
        rdata_ident = rdata_none;
        if (resp_ok && resp_keep) begin
            if (new_pc_unaligned) begin
                rdata_ident = hi_rvi ? rdata_rvi_lo_nv : rdata_rvc_nv;
            end else if (rdata_curr == rvi_part2) begin
                rdata_ident = hi_rvi ? rdata_rvi_lo_rvi_hi : rdata_rvc_rvi_hi;
            end else if (lo_rvi) begin
                rdata_ident = rdata_rvi_hi_rvi_lo;
            end else begin
                rdata_ident = hi_rvi ? rdata_rvi_lo_rvc : rdata_rvc_rvc;
            end
        end
    end

    assign rdata_next = ((rdata_ident == rdata_rvi_lo_nv) ||
                         (rdata_ident == rdata_rvi_lo_rvi_hi) ||
                         (rdata_ident == rdata_rvi_lo_rvc)) ? rvi_part2 : rdata_other;

    //----------------------------
    // Write kind
    //----------------------------
    always_comb begin
        q_we = we_none;
        if (resp_keep) begin
            case (rdata_ident)
                rdata_none:      q_we = resp_er ? we_full : we_none;   // Fault word fills both halves
                rdata_rvc_nv,
                rdata_rvi_lo_nv: q_we = we_hi;
                default:         q_we = we_full;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_pc_unaligned <= 1'b0;
            rdata_curr       <= rdata_other;
        end else if (new_pc_req) begin
            new_pc_unaligned <= new_pc_half;
            rdata_curr       <= rdata_other;
        end else if (resp_keep) begin
            new_pc_unaligned <= 1'b0;
            rdata_curr       <= rdata_next;
        end
    end

endmodule

`default_nettype wire

/* source/instr_queue.sv */
//----------------------------
// Instruction halfword queue
// Pointers, read logic and decoder output
//----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module instr_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        new_pc_req,
    input  logic                        stop_fetch,
    input  ifu_pkg::xlen_t              imem_rdata,
    input  ifu_pkg::mem_resp_e          imem_resp,
    input  logic                        resp_keep,
    input  ifu_pkg::q_we_e              q_we,
    input  logic                        fetch_active,
    input  logic                        idu2ifu_rdy,
    output logic [`IFU_Q_FREE_W_W-1:0]  q_free_words,
    output logic                        ifu2idu_vd,
    output ifu_pkg::instr_t             ifu2idu_instr,
    output logic                        ifu2idu_imem_err,
    output logic                        ifu2idu_err_rvi_hi   // Fault in upper half of RVI
);

    import ifu_pkg::*;

    half_t  q_data [`IFU_Q_SIZE_HALF];
    logic   q_err  [`IFU_Q_SIZE_HALF];
    q_ptr_t q_rptr;
    q_ptr_t q_wptr;
    q_ptr_t q_rptr_inc;
    q_ptr_t q_wptr_inc;
    q_ptr_t q_rptr_next;
    q_ptr_t q_wptr_next;
    q_ptr_t q_ocpd_h;         // Occupied halfwords
    q_ptr_t q_free_h;         // Free halfwords after this cycle's read
    half_t  q_data_head;
    half_t  q_data_next;
    logic   q_err_head;
    logic   q_err_next;
    logic   q_head_rvi;
    logic   q_empty;
    logic   q_flush;
    logic   q_re_half;
    logic   q_re_word;
    logic   q_wr_full;
    logic   q_wr_hi;
    logic   wr_err;

    assign q_flush    = new_pc_req || stop_fetch;
    assign q_empty    = (q_rptr == q_wptr);
    assign q_ocpd_h   = q_wptr - q_rptr;
    assign q_rptr_inc = q_rptr + 1'b1;
    assign q_wptr_inc = q_wptr + 1'b1;

    assign q_data_head = q_data[q_rptr[`IFU_Q_ADR_W-1:0]];
    assign q_data_next = q_data[q_rptr_inc[`IFU_Q_ADR_W-1:0]];
    assign q_err_head  = q_err[q_rptr[`IFU_Q_ADR_W-1:0]];
    assign q_err_next  = q_err[q_rptr_inc[`IFU_Q_ADR_W-1:0]];
    assign q_head_rvi  = &q_data_head[1:0];

    //----------------------------
    // Read side
    //----------------------------
    assign q_re_half = ifu2idu_vd && idu2ifu_rdy && (!q_head_rvi || q_err_head);
    assign q_re_word = ifu2idu_vd && idu2ifu_rdy && q_head_rvi && !q_err_head;

    always_comb begin
        q_rptr_next = q_rptr;
        if (q_re_word) begin
            q_rptr_next = q_rptr + q_ptr_t'(2);
        end else if (q_re_half) begin
            q_rptr_next = q_rptr_inc;
        end
    end

    assign q_free_h     = q_ptr_t'(`IFU_Q_SIZE_HALF) - (q_wptr - q_rptr_next);
    assign q_free_words = q_free_h[`IFU_Q_FREE_W_W:1];   // Whole words only

    //----------------------------
    // Write side
    //----------------------------
    assign q_wr_full = fetch_active && (q_we == we_full);
    assign q_wr_hi   = fetch_active && (q_we == we_hi);
    assign wr_err    = resp_keep && (imem_resp == resp_rdy_er);

    always_comb begin
        q_wptr_next = q_wptr;
        if (q_wr_full) begin
            q_wptr_next = q_wptr + q_ptr_t'(2);
        end else if (q_wr_hi) begin
            q_wptr_next = q_wptr_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (!q_flush) begin
            if (q_wr_full) begin
                q_data[q_wptr[`IFU_Q_ADR_W-1:0]]     <= imem_rdata[15:0];
                q_err[q_wptr[`IFU_Q_ADR_W-1:0]]      <= wr_err;
                q_data[q_wptr_inc[`IFU_Q_ADR_W-1:0]] <= imem_rdata[31:16];
                q_err[q_wptr_inc[`IFU_Q_ADR_W-1:0]]  <= wr_err;
            end else if (q_wr_hi) begin
                q_data[q_wptr[`IFU_Q_ADR_W-1:0]]     <= imem_rdata[31:16];
                q_err[q_wptr[`IFU_Q_ADR_W-1:0]]      <= wr_err;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_rptr <= '0;
            q_wptr <= '0;
        end else if (q_flush) begin
            q_rptr <= '0;                  // Redirect or stop empties the queue
            q_wptr <= '0;
        end else begin
            q_rptr <= q_rptr_next;
            q_wptr <= q_wptr_next;
        end
    end

    //----------------------------
    // Decoder output
    //----------------------------
    always_comb begin
        ifu2idu_vd         = 1'b0;
        ifu2idu_imem_err   = 1'b0;
        ifu2idu_err_rvi_hi = 1'b0;
        if (!q_empty) begin
            if (q_ocpd_h == q_ptr_t'(1)) begin
                ifu2idu_vd       = !q_head_rvi || q_err_head;  // Lone RVI half must wait
                ifu2idu_imem_err = q_err_head;
            end else begin
                ifu2idu_vd         = 1'b1;
                ifu2idu_imem_err   = q_err_head || (q_head_rvi && q_err_next);
                ifu2idu_err_rvi_hi = !q_err_head && q_head_rvi && q_err_next;
            end
        end
    end

    assign ifu2idu_instr = q_head_rvi ? {q_data_next, q_data_head} : instr_t'(q_data_head);

endmodule

`default_nettype wire

/* source/ifu_top.sv */
//----------------------------
// Instruction fetch unit top
// Controller, classifier and queue
//----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module ifu_top (
    input  logic                clk,
    input  logic                rst_n,
    // Instruction memory
    output logic                imem_req,
    input  logic                imem_req_ack,
    output ifu_pkg::xlen_t      imem_addr,
    input  ifu_pkg::xlen_t      imem_rdata,
    input  ifu_pkg::mem_resp_e  imem_resp,
    // Redirect and stop
    input  logic                new_pc_req,
    input  ifu_pkg::xlen_t      new_pc,
    input  logic                stop_fetch,
    // Decoder
    input  logic                idu2ifu_rdy,
    output ifu_pkg::instr_t     ifu2idu_instr,
    output logic                ifu2idu_imem_err,
    output logic                ifu2idu_err_rvi_hi,
    output logic                ifu2idu_vd,
    output logic                ifu_busy
);

    import ifu_pkg::*;

    logic                       resp_keep;
    logic                       fetch_active;
    logic [`IFU_Q_FREE_W_W-1:0] q_free_words;
    q_we_e                      q_we;

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req     (imem_req),
        .imem_req_ack (imem_req_ack),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .q_free_words (q_free_words),
        .resp_keep    (resp_keep),
        .fetch_active (fetch_active),
        .ifu_busy     (ifu_busy)
    );

    rdata_classify u_rdata_classify (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc_half  (new_pc[1]),          // Unaligned start
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .resp_keep    (resp_keep),
        .q_we         (q_we)
    );

    instr_queue u_instr_queue (
        .clk                (clk),
        .rst_n              (rst_n),
        .new_pc_req         (new_pc_req),
        .stop_fetch         (stop_fetch),
        .imem_rdata         (imem_rdata),
        .imem_resp          (imem_resp),
        .resp_keep          (resp_keep),
        .q_we               (q_we),
        .fetch_active       (fetch_active),
        .idu2ifu_rdy        (idu2ifu_rdy),
        .q_free_words       (q_free_words),
        .ifu2idu_vd         (ifu2idu_vd),
        .ifu2idu_instr      (ifu2idu_instr),
        .ifu2idu_imem_err   (ifu2idu_imem_err),
        .ifu2idu_err_rvi_hi (ifu2idu_err_rvi_hi)
    );

endmodule

`default_nettype wire

/* bench/imem_model.sv */
//----------------------------
// Behavioral instruction memory
// Random acknowledge and latency, one fault word
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module imem_model (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req,
    output logic                     ack,
    input  wire ifu_pkg::xlen_t      addr,
    output ifu_pkg::mem_resp_e       resp,
    output ifu_pkg::xlen_t           rdata,
    input  wire logic                fault_en,
    input  wire logic [5:0]          fault_idx     // Word index that answers with an error
);

    import ifu_pkg::*;

    xlen_t       mem [64];
    xlen_t       pend_addr [$];    // Accepted requests, oldest first
    int          pend_due [$];
    int          cyc;
    integer      seed;
    logic [31:0] rnd;
    xlen_t       a;

    initial begin
        seed  = 32'h9040;
        cyc   = 0;
        ack   = 1'b0;
        resp  = resp_notrdy;
        rdata = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = $random(seed);
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            pend_addr.delete();
            pend_due.delete();
        end else if (req && ack) begin
            rnd = $random(seed);
            pend_addr.push_back(addr);
            pend_due.push_back(cyc + 1 + int'(rnd[7:0] % 3));   // 1 to 3 cycles
        end
    end

    always @(negedge clk) begin
        rnd  = $random(seed);
        ack  = |rnd[1:0];
        resp = resp_notrdy;
        if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
            a = pend_addr.pop_front();
            void'(pend_due.pop_front());
            rdata = mem[a[7:2]];
            resp  = (fault_en && a[7:2] == fault_idx) ? resp_rdy_er : resp_rdy_ok;
        end
    end

endmodule

`default_nettype wire

/* bench/ifu_tb.sv */
//----------------------------
// Fetch unit testbench
// Clock, stimulus, reference parser and checks
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

    import ifu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        new_pc_req;
    xlen_t       new_pc;
    logic        stop_fetch;
    logic        idu2ifu_rdy;
    logic        imem_req;
    logic        imem_req_ack;
    xlen_t       imem_addr;
    xlen_t       imem_rdata;
    mem_resp_e   imem_resp;
    instr_t      ifu2idu_instr;
    logic        ifu2idu_imem_err;
    logic        ifu2idu_err_rvi_hi;
    logic        ifu2idu_vd;
    logic        ifu_busy;
    logic        fault_en;
    logic [5:0]  fault_idx;
    logic        req_blocked;    // Set while no request may be issued
    logic [31:0] exp_pc;         // Reference parser position, byte address
    integer      seed;
    logic [31:0] rnd;

    ifu_top UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .imem_req           (imem_req),
        .imem_req_ack       (imem_req_ack),
        .imem_addr          (imem_addr),
        .imem_rdata         (imem_rdata),
        .imem_resp          (imem_resp),
        .new_pc_req         (new_pc_req),
        .new_pc             (new_pc),
        .stop_fetch         (stop_fetch),
        .idu2ifu_rdy        (idu2ifu_rdy),
        .ifu2idu_instr      (ifu2idu_instr),
        .ifu2idu_imem_err   (ifu2idu_imem_err),
        .ifu2idu_err_rvi_hi (ifu2idu_err_rvi_hi),
        .ifu2idu_vd         (ifu2idu_vd),
        .ifu_busy           (ifu_busy)
    );

    imem_model mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (imem_req),
        .ack       (imem_req_ack),
        .addr      (imem_addr),
        .resp      (imem_resp),
        .rdata     (imem_rdata),
        .fault_en  (fault_en),
        .fault_idx (fault_idx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //----------------------------
    // Failure reporting
    //----------------------------
    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |-> (imem_addr[1:0] == 2'b00))
        else report_value("imem_addr[1:0]", 32'(imem_addr[1:0]), 32'h0);

    a_req_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        req_blocked |-> !imem_req)
        else report_value("imem_req", 32'(imem_req), 32'h0);

    //----------------------------
    // Reference parser
    //----------------------------
    function automatic logic [15:0] half_at(input logic [31:0] pc);
        logic [31:0] w;
        w = mem_i.mem[pc[7:2]];
        return pc[1] ? w[31:16] : w[15:0];
    endfunction

    // Consumes count instructions, stops early at one that starts in the fault word
    task automatic run_stream(input int count, input logic rand_rdy);
        int          taken;
        int          wait_cyc;
        logic [15:0] lo;
        logic [31:0] hi_pc;
        logic [31:0] exp_instr;
        logic        is_rvi;
        logic        lo_f;
        logic        hi_f;
        taken    = 0;
        wait_cyc = 0;
        while (taken < count) begin
            @(negedge clk);
            rnd = $random(seed);
            idu2ifu_rdy = rand_rdy ? rnd[0] : 1'b1;
            #1;
            if (ifu2idu_vd && idu2ifu_rdy) begin
                lo     = half_at(exp_pc);
                hi_pc  = exp_pc + 32'd2;
                is_rvi = &lo[1:0];
                lo_f   = fault_en && (exp_pc[7:2] == fault_idx);
                hi_f   = fault_en && (hi_pc[7:2] == fault_idx);
                exp_instr = is_rvi ? {half_at(hi_pc), lo} : {16'h0, lo};
                if (lo_f) begin
                    assert (ifu2idu_imem_err) else
                        report_value("ifu2idu_imem_err", 32'(ifu2idu_imem_err), 32'h1);
                    assert (!ifu2idu_err_rvi_hi) else
                        report_value("ifu2idu_err_rvi_hi", 32'(ifu2idu_err_rvi_hi), 32'h0);
                    taken = count;
                end else begin
                    assert (ifu2idu_instr == exp_instr) else
                        report_value("ifu2idu_instr", ifu2idu_instr, exp_instr);
                    assert (ifu2idu_imem_err == (is_rvi && hi_f)) else
                        report_value("ifu2idu_imem_err", 32'(ifu2idu_imem_err),
                                     32'(is_rvi && hi_f));
                    assert (ifu2idu_err_rvi_hi == (is_rvi && hi_f)) else
                        report_value("ifu2idu_err_rvi_hi", 32'(ifu2idu_err_rvi_hi),
                                     32'(is_rvi && hi_f));
                    exp_pc = is_rvi ? exp_pc + 32'd4 : hi_pc;
                    taken  = taken + 1;
                end
                wait_cyc = 0;
            end else begin
                wait_cyc = wait_cyc + 1;
                if (wait_cyc > 100) begin
                    report_error("Timeout: no instruction handed to the decoder");
                end
            end
        end
    endtask

    task automatic redirect(input logic [31:0] pc);
        @(negedge clk);
        req_blocked = 1'b0;
        new_pc_req  = 1'b1;
        new_pc      = pc;
        idu2ifu_rdy = 1'b0;
        exp_pc      = pc;
        @(negedge clk);
        new_pc_req = 1'b0;
        #1;
        assert (!ifu2idu_vd) else report_value("ifu2idu_vd", 32'(ifu2idu_vd), 32'h0);
    endtask

    // Idle cycles with fetch off
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            #1;
            assert (!ifu_busy) else report_value("ifu_busy", 32'(ifu_busy), 32'h0);
            assert (!ifu2idu_vd) else report_value("ifu2idu_vd", 32'(ifu2idu_vd), 32'h0);
        end
    endtask

    //----------------------------
    // Main sequence
    //----------------------------
    initial begin
        seed        = 32'h9040;
        rst_n       = 1'b0;
        new_pc_req  = 1'b0;
        new_pc      = '0;
        stop_fetch  = 1'b0;
        idu2ifu_rdy = 1'b0;
        fault_en    = 1'b0;
        fault_idx   = 6'd21;
        req_blocked = 1'b0;
        exp_pc      = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #1;
        assert (!imem_req) else report_value("imem_req", 32'(imem_req), 32'h0);
        assert (!ifu_busy) else report_value("ifu_busy", 32'(ifu_busy), 32'h0);
        assert (!ifu2idu_vd) else report_value("ifu2idu_vd", 32'(ifu2idu_vd), 32'h0);

        redirect(32'h0000_0010);           // Aligned start
        run_stream(40, 1'b0);
        redirect(32'h0000_0046);           // Unaligned start
        run_stream(40, 1'b1);
        redirect(32'h0000_0020);
        run_stream(10, 1'b1);
        redirect(32'h0000_0082);           // Mid-stream redirect
        run_stream(30, 1'b1);

        // RVC then a spanning RVI whose upper half sits in the fault word
        mem_i.mem[20] = 32'h1233_4501;
        fault_en = 1'b1;
        redirect(32'h0000_0050);
        run_stream(10, 1'b1);
        @(negedge clk);
        #1;
        assert (!ifu_busy) else report_value("ifu_busy", 32'(ifu_busy), 32'h0);
        req_blocked = 1'b1;
        repeat (10) @(negedge clk);
        fault_en = 1'b0;

        redirect(32'h0000_0020);
        run_stream(5, 1'b1);
        @(negedge clk);
        stop_fetch  = 1'b1;
        idu2ifu_rdy = 1'b0;
        @(negedge clk);
        stop_fetch  = 1'b0;
        req_blocked = 1'b1;
        #1;
        assert (!ifu_busy) else report_value("ifu_busy", 32'(ifu_busy), 32'h0);
        assert (!ifu2idu_vd) else report_value("ifu2idu_vd", 32'(ifu2idu_vd), 32'h0);
        check_quiet(10);

        redirect(32'h0000_0000);           // Restart after stop
        run_stream(10, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/ifu_pkg.sv
source/fetch_ctrl.sv
source/rdata_classify.sv
source/instr_queue.sv
source/ifu_top.sv
bench/imem_model.sv
bench/ifu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ifu_tb \
    -f list.f \
    -o Vifu_tb

./obj_dir/Vifu_tb
